// File: hdl/lc4_decoder.sv
`timescale 1ns/1ns

module lc4_decoder (
    input  logic [lc4_pkg::WORD_W-1:0] i_insn,
    input  logic [lc4_pkg::WORD_W-1:0] i_pc,
    input  lc4_pkg::stall_e            i_stall,
    output lc4_pkg::uop_t              o_uop
);

    always_comb begin
        o_uop = '0;
        o_uop.stall = i_stall;
        o_uop.insn = i_insn;
        o_uop.pc = i_pc;
        o_uop.op = lc4_pkg::OP_NOP;
        o_uop.rd = i_insn[11:9];
        o_uop.rs = i_insn[8:6];
        o_uop.rt = i_insn[2:0];

        // bubbles carry no register use at all
        if (i_stall == lc4_pkg::STALL_NONE) begin
            case (i_insn[15:12])
                lc4_pkg::OPC_ARITH: begin
                    if (i_insn[5]) begin
                        o_uop.op = lc4_pkg::OP_ADDI;
                        o_uop.reads_rs = 1'b1;
                        o_uop.writes_rd = 1'b1;
                        o_uop.imm = {{11{i_insn[4]}}, i_insn[4:0]};
                    end else if (i_insn[4:3] != 2'b11) begin
                        // sub-opcode 011 is DIV, not supported here
                        o_uop.reads_rs = 1'b1;
                        o_uop.reads_rt = 1'b1;
                        o_uop.writes_rd = 1'b1;
                        case (i_insn[4:3])
                            2'b00:   o_uop.op = lc4_pkg::OP_ADD;
                            2'b01:   o_uop.op = lc4_pkg::OP_MUL;
                            default: o_uop.op = lc4_pkg::OP_SUB;
                        endcase
                    end
                end
                lc4_pkg::OPC_LOGIC: begin
                    o_uop.reads_rs = 1'b1;
                    o_uop.writes_rd = 1'b1;
                    if (i_insn[5]) begin
                        o_uop.op = lc4_pkg::OP_ANDI;
                        o_uop.imm = {{11{i_insn[4]}}, i_insn[4:0]};
                    end else begin
                        // NOT is the only one without a second operand
                        o_uop.reads_rt = (i_insn[4:3] != 2'b01);
                        case (i_insn[4:3])
                            2'b00:   o_uop.op = lc4_pkg::OP_AND;
                            2'b01:   o_uop.op = lc4_pkg::OP_NOT;
                            2'b10:   o_uop.op = lc4_pkg::OP_OR;
                            default: o_uop.op = lc4_pkg::OP_XOR;
                        endcase
                    end
                end
                lc4_pkg::OPC_CONST: begin
                    o_uop.op = lc4_pkg::OP_CONST;
                    o_uop.writes_rd = 1'b1;
                    o_uop.imm = {{7{i_insn[8]}}, i_insn[8:0]};
                end
                lc4_pkg::OPC_HICONST: begin
                    if (i_insn[8]) begin
                        // keeps the low byte of rd, so rd is also a source
                        o_uop.op = lc4_pkg::OP_HICONST;
                        o_uop.rs = i_insn[11:9];
                        o_uop.reads_rs = 1'b1;
                        o_uop.writes_rd = 1'b1;
                        o_uop.imm = {8'h00, i_insn[7:0]};
                    end
                end
                default: begin
                    o_uop.op = lc4_pkg::OP_NOP;
                end
            endcase
        end
    end

endmodule

// File: hdl/lc4_exec_lane.sv
`timescale 1ns/1ns

module lc4_exec_lane (
    input  logic                       gwe,
    input  logic                       i_arst_n,
    input  lc4_pkg::uop_t              i_uop,
    input  logic [lc4_pkg::WORD_W-1:0] i_rs,
    input  logic [lc4_pkg::WORD_W-1:0] i_rt,
    input  lc4_pkg::wb_t [1:0]         i_wb_all,
    output lc4_pkg::wb_t               o_wb,
    output lc4_pkg::retire_t           o_retire
);

    lc4_pkg::uop_t              x_uop_q;
    logic [lc4_pkg::WORD_W-1:0] x_rs_q;
    logic [lc4_pkg::WORD_W-1:0] x_rt_q;
    logic [lc4_pkg::WORD_W-1:0] rs_val;
    logic [lc4_pkg::WORD_W-1:0] rt_val;
    logic [lc4_pkg::WORD_W-1:0] alu_result;
    lc4_pkg::retire_t           w_q;

    // newest W result wins, lane B is younger than lane A
    function automatic logic [lc4_pkg::WORD_W-1:0] bypass(
        input logic                       used,
        input logic [lc4_pkg::REG_W-1:0]  sel,
        input logic [lc4_pkg::WORD_W-1:0] reg_val,
        input lc4_pkg::wb_t [1:0]         wb
    );
        logic [lc4_pkg::WORD_W-1:0] val;
        val = reg_val;
        if (used && wb[1].we && (wb[1].wsel == sel)) begin
            val = wb[1].data;
        end else if (used && wb[0].we && (wb[0].wsel == sel)) begin
            val = wb[0].data;
        end
        return val;
    endfunction

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            x_uop_q <= '0;
            x_uop_q.stall <= lc4_pkg::STALL_RESET;
        end else begin
            x_uop_q <= i_uop;
        end
    end

    always_ff @(posedge gwe) begin
        x_rs_q <= i_rs;
        x_rt_q <= i_rt;
    end

    assign rs_val = bypass(x_uop_q.reads_rs, x_uop_q.rs, x_rs_q, i_wb_all);
    assign rt_val = bypass(x_uop_q.reads_rt, x_uop_q.rt, x_rt_q, i_wb_all);

    always_comb begin
        case (x_uop_q.op)
            lc4_pkg::OP_ADD:     alu_result = rs_val + rt_val;
            lc4_pkg::OP_MUL:     alu_result = rs_val * rt_val;
            lc4_pkg::OP_SUB:     alu_result = rs_val - rt_val;
            lc4_pkg::OP_ADDI:    alu_result = rs_val + x_uop_q.imm;
            lc4_pkg::OP_AND:     alu_result = rs_val & rt_val;
            lc4_pkg::OP_NOT:     alu_result = ~rs_val;
            lc4_pkg::OP_OR:      alu_result = rs_val | rt_val;
            lc4_pkg::OP_XOR:     alu_result = rs_val ^ rt_val;
            lc4_pkg::OP_ANDI:    alu_result = rs_val & x_uop_q.imm;
            lc4_pkg::OP_CONST:   alu_result = x_uop_q.imm;
            // upper byte from the immediate, lower byte kept from rd
            lc4_pkg::OP_HICONST: alu_result = (rs_val & 16'h00ff) | {x_uop_q.imm[7:0], 8'h00};
            default:             alu_result = '0;
        endcase
    end

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            w_q <= '0;
            w_q.stall <= lc4_pkg::STALL_RESET;
        end else begin
            w_q.stall <= x_uop_q.stall;
            w_q.pc <= x_uop_q.pc;
            w_q.insn <= x_uop_q.insn;
            w_q.we <= x_uop_q.writes_rd;
            w_q.wsel <= x_uop_q.rd;
            w_q.data <= alu_result;
        end
    end

    assign o_wb.we = w_q.we;
    assign o_wb.wsel = w_q.wsel;
    assign o_wb.data = w_q.data;
    assign o_retire = w_q;

    // bubbles from reset or a split pair must never write a register
    a_bubble_no_write: assert property (@(posedge gwe) disable iff (!i_arst_n)
        (x_uop_q.stall != lc4_pkg::STALL_NONE) |-> !x_uop_q.writes_rd);

endmodule

// File: hdl/lc4_fetch_issue.sv
`timescale 1ns/1ns

module lc4_fetch_issue #(
    parameter logic [lc4_pkg::WORD_W-1:0] P_RESET_PC = 16'h8200
) (
    input  logic                                gwe,
    input  logic                                i_arst_n,
    input  logic [lc4_pkg::WORD_W-1:0]          i_insn_a,
    input  logic [lc4_pkg::WORD_W-1:0]          i_insn_b,
    output logic [lc4_pkg::WORD_W-1:0]          o_cur_pc,
    output logic [1:0][lc4_pkg::REG_W-1:0]      o_rs_sel,
    output logic [1:0][lc4_pkg::REG_W-1:0]      o_rt_sel,
    input  logic [1:0][lc4_pkg::WORD_W-1:0]     i_rs_data,
    input  logic [1:0][lc4_pkg::WORD_W-1:0]     i_rt_data,
    output lc4_pkg::uop_t [1:0]                 o_issue,
    output logic [1:0][lc4_pkg::WORD_W-1:0]     o_issue_rs,
    output logic [1:0][lc4_pkg::WORD_W-1:0]     o_issue_rt
);

    logic [lc4_pkg::WORD_W-1:0]      pc_q;
    logic [lc4_pkg::WORD_W-1:0]      pc_next;
    logic [lc4_pkg::WORD_W-1:0]      pc_plus1;
    logic [1:0][lc4_pkg::WORD_W-1:0] d_insn_q;
    logic [1:0][lc4_pkg::WORD_W-1:0] d_insn_next;
    logic [1:0][lc4_pkg::WORD_W-1:0] d_pc_q;
    logic [1:0][lc4_pkg::WORD_W-1:0] d_pc_next;
    lc4_pkg::stall_e                 d_stall_q [2];
    lc4_pkg::stall_e                 d_stall_next [2];
    lc4_pkg::uop_t                   uop_a;
    lc4_pkg::uop_t                   uop_b;
    logic                            b_needs_a;

    lc4_decoder i_decoder_a (
        .i_insn  (d_insn_q[0]),
        .i_pc    (d_pc_q[0]),
        .i_stall (d_stall_q[0]),
        .o_uop   (uop_a)
    );

    lc4_decoder i_decoder_b (
        .i_insn  (d_insn_q[1]),
        .i_pc    (d_pc_q[1]),
        .i_stall (d_stall_q[1]),
        .o_uop   (uop_b)
    );

    // lane B reads what lane A of the same pair writes
    assign b_needs_a = uop_a.writes_rd &&
                       ((uop_b.reads_rs && (uop_b.rs == uop_a.rd)) ||
                        (uop_b.reads_rt && (uop_b.rt == uop_a.rd)));

    assign o_cur_pc = pc_q;
    assign pc_plus1 = pc_q + 16'd1;

    // two register file read ports per slot
    assign o_rs_sel[0] = uop_a.rs;
    assign o_rt_sel[0] = uop_a.rt;
    assign o_rs_sel[1] = uop_b.rs;
    assign o_rt_sel[1] = uop_b.rt;
    assign o_issue_rs = i_rs_data;
    assign o_issue_rt = i_rt_data;

    always_comb begin
        o_issue[0] = uop_a;
        o_issue[1] = uop_b;
        if (b_needs_a) begin
            // held-back B leaves an empty slot in X lane B
            o_issue[1] = '0;
            o_issue[1].stall = lc4_pkg::STALL_SUPER;
            o_issue[1].op = lc4_pkg::OP_NOP;
        end
    end

    // steer the next D pair
    always_comb begin
        if (b_needs_a) begin
            d_insn_next[0] = d_insn_q[1];
            d_pc_next[0] = d_pc_q[1];
            d_stall_next[0] = d_stall_q[1];
            d_insn_next[1] = i_insn_a;
            d_pc_next[1] = pc_q;
            d_stall_next[1] = lc4_pkg::STALL_NONE;
            pc_next = pc_plus1;
        end else begin
            d_insn_next[0] = i_insn_a;
            d_pc_next[0] = pc_q;
            d_stall_next[0] = lc4_pkg::STALL_NONE;
            d_insn_next[1] = i_insn_b;
            d_pc_next[1] = pc_plus1;
            d_stall_next[1] = lc4_pkg::STALL_NONE;
            pc_next = pc_q + 16'd2;
        end
    end

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q <= P_RESET_PC;
            d_stall_q[0] <= lc4_pkg::STALL_RESET;
            d_stall_q[1] <= lc4_pkg::STALL_RESET;
        end else begin
            pc_q <= pc_next;
            d_stall_q <= d_stall_next;
        end
    end

    always_ff @(posedge gwe) begin
        d_insn_q <= d_insn_next;
        d_pc_q <= d_pc_next;
    end

    // an issued pair never carries a lane A to lane B dependence
    a_pair_indep: assert property (@(posedge gwe) disable iff (!i_arst_n)
        o_issue[0].writes_rd |->
            !((o_issue[1].reads_rs && (o_issue[1].rs == o_issue[0].rd)) ||
              (o_issue[1].reads_rt && (o_issue[1].rt == o_issue[0].rd))));

endmodule

// File: hdl/lc4_pkg.sv
package lc4_pkg;

    // data path and PC width
    localparam int WORD_W = 16;
    // register select width, eight registers
    localparam int REG_W = 3;

    // LC4 major opcodes that the core decodes
    typedef enum logic [3:0] {
        OPC_BR      = 4'b0000,
        OPC_ARITH   = 4'b0001,
        OPC_LOGIC   = 4'b0101,
        OPC_CONST   = 4'b1001,
        OPC_HICONST = 4'b1101
    } lc4_opcode_e;

    // internal operation of one decoded instruction
    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADD,
        OP_MUL,
        OP_SUB,
        OP_ADDI,
        OP_AND,
        OP_NOT,
        OP_OR,
        OP_XOR,
        OP_ANDI,
        OP_CONST,
        OP_HICONST
    } lc4_op_e;

    // retire stall codes, values follow the LC4 test outputs
    typedef enum logic [1:0] {
        STALL_NONE  = 2'd0,
        STALL_SUPER = 2'd1,
        STALL_RESET = 2'd2
    } stall_e;

    // one decoded instruction on its way through D and X
    typedef struct packed {
        stall_e             stall;
        logic [WORD_W-1:0]  insn;
        logic [WORD_W-1:0]  pc;
        lc4_op_e            op;
        logic [REG_W-1:0]   rs;
        logic [REG_W-1:0]   rt;
        logic [REG_W-1:0]   rd;
        logic               reads_rs;
        logic               reads_rt;
        logic               writes_rd;
        logic [WORD_W-1:0]  imm;
    } uop_t;

    // one register write
    typedef struct packed {
        logic               we;
        logic [REG_W-1:0]   wsel;
        logic [WORD_W-1:0]  data;
    } wb_t;

    // what a lane shows at W
    typedef struct packed {
        stall_e             stall;
        logic [WORD_W-1:0]  pc;
        logic [WORD_W-1:0]  insn;
        logic               we;
        logic [REG_W-1:0]   wsel;
        logic [WORD_W-1:0]  data;
    } retire_t;

endpackage

// File: hdl/lc4_regfile_2w.sv
`timescale 1ns/1ns

module lc4_regfile_2w (
    input  logic                            gwe,
    input  logic                            i_arst_n,
    input  logic [1:0][lc4_pkg::REG_W-1:0]  i_rs_sel,
    input  logic [1:0][lc4_pkg::REG_W-1:0]  i_rt_sel,
    output logic [1:0][lc4_pkg::WORD_W-1:0] o_rs_data,
    output logic [1:0][lc4_pkg::WORD_W-1:0] o_rt_data,
    input  lc4_pkg::wb_t [1:0]              i_wb
);

    localparam int NUM_REGS = 1 << lc4_pkg::REG_W;

    logic [NUM_REGS-1:0][lc4_pkg::WORD_W-1:0] regs_q;

    // same-cycle write shows through, lane B ahead of lane A
    function automatic logic [lc4_pkg::WORD_W-1:0] read_port(
        input logic [lc4_pkg::REG_W-1:0]              sel,
        input logic [NUM_REGS-1:0][lc4_pkg::WORD_W-1:0] regs,
        input lc4_pkg::wb_t [1:0]                     wb
    );
        logic [lc4_pkg::WORD_W-1:0] val;
        val = regs[sel];
        if (wb[1].we && (wb[1].wsel == sel)) begin
            val = wb[1].data;
        end else if (wb[0].we && (wb[0].wsel == sel)) begin
            val = wb[0].data;
        end
        return val;
    endfunction

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            regs_q <= '0;
        end else begin
            if (i_wb[0].we) begin
                regs_q[i_wb[0].wsel] <= i_wb[0].data;
            end
            // later assignment, so lane B wins a shared destination
            if (i_wb[1].we) begin
                regs_q[i_wb[1].wsel] <= i_wb[1].data;
            end
        end
    end

    always_comb begin
        for (int port = 0; port < 2; port++) begin
            o_rs_data[port] = read_port(i_rs_sel[port], regs_q, i_wb);
            o_rt_data[port] = read_port(i_rt_sel[port], regs_q, i_wb);
        end
    end

endmodule

// File: hdl/lc4_superscalar.sv
`timescale 1ns/1ns

module lc4_superscalar #(
    parameter logic [lc4_pkg::WORD_W-1:0] P_RESET_PC = 16'h8200
) (
    input  logic                       gwe,
    input  logic                       i_arst_n,
    output logic [lc4_pkg::WORD_W-1:0] o_cur_pc,
    input  logic [lc4_pkg::WORD_W-1:0] i_insn_a,
    input  logic [lc4_pkg::WORD_W-1:0] i_insn_b,
    output lc4_pkg::retire_t [1:0]     o_retire
);

    logic [1:0][lc4_pkg::REG_W-1:0]  rs_sel;
    logic [1:0][lc4_pkg::REG_W-1:0]  rt_sel;
    logic [1:0][lc4_pkg::WORD_W-1:0] rs_data;
    logic [1:0][lc4_pkg::WORD_W-1:0] rt_data;
    logic [1:0][lc4_pkg::WORD_W-1:0] issue_rs;
    logic [1:0][lc4_pkg::WORD_W-1:0] issue_rt;
    lc4_pkg::uop_t [1:0]             issue;
    lc4_pkg::wb_t [1:0]              wb;

    lc4_fetch_issue #(
        .P_RESET_PC (P_RESET_PC)
    ) i_fetch_issue (
        .gwe        (gwe),
        .i_arst_n   (i_arst_n),
        .i_insn_a   (i_insn_a),
        .i_insn_b   (i_insn_b),
        .o_cur_pc   (o_cur_pc),
        .o_rs_sel   (rs_sel),
        .o_rt_sel   (rt_sel),
        .i_rs_data  (rs_data),
        .i_rt_data  (rt_data),
        .o_issue    (issue),
        .o_issue_rs (issue_rs),
        .o_issue_rt (issue_rt)
    );

    // lane 0 is A, lane 1 is B
    for (genvar lane = 0; lane < 2; lane++) begin : g_lane
        lc4_exec_lane i_lane (
            .gwe      (gwe),
            .i_arst_n (i_arst_n),
            .i_uop    (issue[lane]),
            .i_rs     (issue_rs[lane]),
            .i_rt     (issue_rt[lane]),
            .i_wb_all (wb),
            .o_wb     (wb[lane]),
            .o_retire (o_retire[lane])
        );
    end

    lc4_regfile_2w i_regfile (
        .gwe       (gwe),
        .i_arst_n  (i_arst_n),
        .i_rs_sel  (rs_sel),
        .i_rt_sel  (rt_sel),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data),
        .i_wb      (wb)
    );

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_lc4_superscalar \
    -f vlog.f \
    -o tb_lc4_superscalar

./obj_dir/tb_lc4_superscalar 2>&1 | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished without failure"

// File: verif/tb_lc4_program.svh
localparam int PROG_LEN = 26;

// columns: instruction, writes a register, expected rd, expected value
// values assume every register starts at zero
localparam prog_entry_t PROG_TABLE [PROG_LEN] = '{
    // CONST R1,#5 and CONST R2,#-3
    {16'h9205, 1'b1, 3'd1, 16'h0005},
    {16'h95FD, 1'b1, 3'd2, 16'hFFFD},
    // ADD R3,R1,R2 and MUL R4,R1,R1 bypass from both W lanes
    {16'h1642, 1'b1, 3'd3, 16'h0002},
    {16'h1849, 1'b1, 3'd4, 16'h0019},
    // SUB R5,R3,R4 then ADDI R6,R5,#4, a split pair
    {16'h1AD4, 1'b1, 3'd5, 16'hFFE9},
    {16'h1D64, 1'b1, 3'd6, 16'hFFED},
    // AND R7,R1,R4 and NOT R0,R6
    {16'h5E44, 1'b1, 3'd7, 16'h0001},
    {16'h5188, 1'b1, 3'd0, 16'h0012},
    // OR R1,R0,R2 splits from the NOT, then XOR R2,R7,R5
    {16'h5212, 1'b1, 3'd1, 16'hFFFF},
    {16'h55DD, 1'b1, 3'd2, 16'hFFE8},
    // ANDI R3,R1,#7 and a NOP
    {16'h5667, 1'b1, 3'd3, 16'h0007},
    {16'h0000, 1'b0, 3'd0, 16'h0000},
    // both lanes write R4, lane B's value must stick
    {16'h99FF, 1'b1, 3'd4, 16'hFFFF},
    {16'h9864, 1'b1, 3'd4, 16'h0064},
    // HICONST R4,#0xAB keeps the low byte from lane B, ADD R5,R3,R3
    {16'hD9AB, 1'b1, 3'd4, 16'hAB64},
    {16'h1AC3, 1'b1, 3'd5, 16'h000E},
    // ADD R6,R4,R0, MUL R7,R6,R5, SUB R0,R7,R1 give two splits in a row
    {16'h1D00, 1'b1, 3'd6, 16'hAB76},
    {16'h1F8D, 1'b1, 3'd7, 16'h6074},
    {16'h11D1, 1'b1, 3'd0, 16'h6075},
    // HICONST R1,#0x12
    {16'hD312, 1'b1, 3'd1, 16'h12FF},
    // ADD R2,R0,R1 then NOT R3,R2 splits
    {16'h1401, 1'b1, 3'd2, 16'h7374},
    {16'h5688, 1'b1, 3'd3, 16'h8C8B},
    // DIV is outside the kept set and retires as a NOP
    {16'h1A5A, 1'b0, 3'd0, 16'h0000},
    // XOR R4,R3,R7, ADDI R6,R4,#-16 splits, ANDI R7,R4,#-2
    {16'h58DF, 1'b1, 3'd4, 16'hECFF},
    {16'h1D30, 1'b1, 3'd6, 16'hECEF},
    {16'h5F3E, 1'b1, 3'd7, 16'hECFE}
};

// File: verif/tb_lc4_superscalar.sv
`timescale 1ns/1ns

module tb_lc4_superscalar;

    localparam logic [lc4_pkg::WORD_W-1:0] P_RESET_PC = 16'h8200;
    localparam logic [lc4_pkg::WORD_W-1:0] NOP_INSN = 16'h0000;
    localparam int RESET_CYCLES = 4;

    typedef struct packed {
        logic [lc4_pkg::WORD_W-1:0] insn;
        logic                       we;
        logic [lc4_pkg::REG_W-1:0]  rd;
        logic [lc4_pkg::WORD_W-1:0] value;
    } prog_entry_t;

    `include "tb_lc4_program.svh"

    // every pair needs at most two cycles, plus reset and pipeline fill
    localparam int WATCHDOG_CYCLES = PROG_LEN * 2 + 20;

    logic                       gwe;
    logic                       i_arst_n = 1'b0;
    logic [lc4_pkg::WORD_W-1:0] i_insn_a = NOP_INSN;
    logic [lc4_pkg::WORD_W-1:0] i_insn_b = NOP_INSN;
    logic [lc4_pkg::WORD_W-1:0] o_cur_pc;
    lc4_pkg::retire_t [1:0]     o_retire;

    int cycle_count = 0;
    int next_idx = 0;
    int super_count = 0;
    int expected_splits = 0;
    bit retire_seen = 1'b0;
    int value_errors = 0;
    int order_errors = 0;
    int stall_errors = 0;
    int split_errors = 0;

    lc4_superscalar #(
        .P_RESET_PC (P_RESET_PC)
    ) i_lc4_superscalar (
        .gwe      (gwe),
        .i_arst_n (i_arst_n),
        .o_cur_pc (o_cur_pc),
        .i_insn_a (i_insn_a),
        .i_insn_b (i_insn_b),
        .o_retire (o_retire)
    );

    initial begin
        gwe = 1'b0;
        forever #2 gwe = ~gwe;
    end

    always @(posedge gwe) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == RESET_CYCLES - 1) begin
            i_arst_n <= 1'b1;
        end
    end

    // word at a PC, NOP outside the program
    function automatic logic [lc4_pkg::WORD_W-1:0] fetch_word(
        input logic [lc4_pkg::WORD_W-1:0] addr
    );
        logic [lc4_pkg::WORD_W-1:0] offset;
        logic [lc4_pkg::WORD_W-1:0] word;
        offset = addr - P_RESET_PC;
        word = NOP_INSN;
        if (int'(offset) < PROG_LEN) begin
            word = PROG_TABLE[int'(offset)].insn;
        end
        return word;
    endfunction

    // instruction memory, answers the PC once it has settled after the edge
    always @(posedge gwe) begin
        #1;
        i_insn_a <= fetch_word(o_cur_pc);
        i_insn_b <= fetch_word(o_cur_pc + 16'd1);
    end

    // registers an LC4 instruction reads, one bit each
    function automatic logic [7:0] source_mask(input logic [lc4_pkg::WORD_W-1:0] insn);
        logic [7:0] rs_bit;
        logic [7:0] rt_bit;
        logic [7:0] mask;
        rs_bit = 8'b1 << insn[8:6];
        rt_bit = 8'b1 << insn[2:0];
        mask = 8'h00;
        case (insn[15:12])
            4'b0001: begin
                // imm5 form reads rs only, DIV is dropped
                if (insn[5]) begin
                    mask = rs_bit;
                end else if (insn[4:3] != 2'b11) begin
                    mask = rs_bit | rt_bit;
                end
            end
            4'b0101: begin
                if (insn[5] || (insn[4:3] == 2'b01)) begin
                    mask = rs_bit;
                end else begin
                    mask = rs_bit | rt_bit;
                end
            end
            4'b1101: begin
                if (insn[8]) begin
                    mask = 8'b1 << insn[11:9];
                end
            end
            default: mask = 8'h00;
        endcase
        return mask;
    endfunction

    // walk the program in pairs, a B that reads A's rd starts the next pair
    function automatic int count_splits();
        int idx;
        int splits;
        logic [7:0] reads;
        idx = 0;
        splits = 0;
        while (idx < PROG_LEN) begin
            reads = 8'h00;
            if (idx + 1 < PROG_LEN) begin
                reads = source_mask(PROG_TABLE[idx + 1].insn);
            end
            if (PROG_TABLE[idx].we && reads[PROG_TABLE[idx].rd]) begin
                splits++;
                idx += 1;
            end else begin
                idx += 2;
            end
        end
        return splits;
    endfunction

    task automatic check_lane(input lc4_pkg::retire_t r, input int lane);
        prog_entry_t exp;
        logic [lc4_pkg::WORD_W-1:0] exp_pc;
        exp_pc = P_RESET_PC + 16'(next_idx);
        // beyond the table the core runs into NOPs
        exp = '0;
        if (next_idx < PROG_LEN) begin
            exp = PROG_TABLE[next_idx];
        end
        case (r.stall)
            lc4_pkg::STALL_NONE: begin
                retire_seen = 1'b1;
                assert ((r.pc == exp_pc) && (r.insn == exp.insn)) else begin
                    order_errors++;
                    $display("[ERROR] %0t: lane %0d retired pc %h insn %h, expected pc %h insn %h",
                             $time, lane, r.pc, r.insn, exp_pc, exp.insn);
                end
                assert ((r.we == exp.we) &&
                        (!exp.we || ((r.wsel == exp.rd) && (r.data == exp.value)))) else begin
                    value_errors++;
                    $display("[ERROR] %0t: pc %h wrote we %b R%0d = %h, expected we %b R%0d = %h",
                             $time, r.pc, r.we, r.wsel, r.data, exp.we, exp.rd, exp.value);
                end
                next_idx++;
            end
            lc4_pkg::STALL_SUPER: begin
                assert ((lane == 1) && !r.we) else begin
                    stall_errors++;
                    $display("[ERROR] %0t: split bubble in lane %0d with we %b",
                             $time, lane, r.we);
                end
                if (lane == 1) begin
                    super_count++;
                end
            end
            default: begin
                // reset bubbles only ahead of the first retirement
                assert (!retire_seen && (r.stall == lc4_pkg::STALL_RESET) && !r.we) else begin
                    stall_errors++;
                    $display("[ERROR] %0t: lane %0d shows stall code %0d with we %b",
                             $time, lane, r.stall, r.we);
                end
            end
        endcase
    endtask

    always @(negedge gwe) begin
        if (cycle_count > 0) begin
            if (!i_arst_n) begin
                assert (o_cur_pc == P_RESET_PC) else begin
                    order_errors++;
                    $display("[ERROR] %0t: pc %h in reset, expected %h",
                             $time, o_cur_pc, P_RESET_PC);
                end
            end
            // lane A is older than lane B
            check_lane(o_retire[0], 0);
            check_lane(o_retire[1], 1);
        end
    end

    function automatic int total_errors();
        return value_errors + order_errors + stall_errors + split_errors;
    endfunction

    task automatic print_summary();
        $display("retired %0d of %0d, splits %0d, errors: value %0d order %0d stall %0d split %0d",
                 next_idx, PROG_LEN, super_count, value_errors, order_errors,
                 stall_errors, split_errors);
    endtask

    initial begin
        expected_splits = count_splits();
        while (next_idx < PROG_LEN) begin
            @(posedge gwe);
        end
        // trailing NOPs pass the checker too
        repeat (2) @(posedge gwe);
        assert (super_count == expected_splits) else begin
            split_errors++;
            $display("[ERROR] %0t: %0d split bubbles in lane B, expected %0d",
                     $time, super_count, expected_splits);
        end
        print_summary();
        if (total_errors() == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge gwe);
        $display("timeout: the program did not retire within %0d cycles", WATCHDOG_CYCLES);
        print_summary();
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+verif
hdl/lc4_pkg.sv
hdl/lc4_decoder.sv
hdl/lc4_regfile_2w.sv
hdl/lc4_exec_lane.sv
hdl/lc4_fetch_issue.sv
hdl/lc4_superscalar.sv
verif/tb_lc4_superscalar.sv
